//--- source/f2a_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, register map and structs for the
// fifo to axi-stream subsystem
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package f2a_pkg;

   localparam int DATA_W_DEF = 32;
   localparam int LEN_W      = 8;
   localparam int DEPTH_DEF  = 8;
   localparam int CFG_ADDR_W = 2;

   // register map
   localparam logic [CFG_ADDR_W-1:0] ADDR_CTRL   = 2'd0;
   localparam logic [CFG_ADDR_W-1:0] ADDR_LEN    = 2'd1;
   localparam logic [CFG_ADDR_W-1:0] ADDR_STATUS = 2'd2;

   typedef struct packed {
      logic             en;
      logic [LEN_W-1:0] len;
   } f2a_cfg_t;

   typedef struct packed {
      logic [1:0] level;
      logic [7:0] fifo_count;
   } f2a_status_t;

   typedef struct packed {
      logic                  tvalid;
      logic                  tlast;
      logic [DATA_W_DEF-1:0] tdata;
   } axis_m_t;

   typedef struct packed {
      logic                  valid;
      logic [DATA_W_DEF-1:0] data;
   } in_word_t;

endpackage

//--- source/f2a_cfg_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control, length and status registers with a sticky
// overflow flag for writes into a full fifo
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module f2a_cfg_regs
   import f2a_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   // register port
   input  logic                  cfg_we_i,
   input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [31:0]           cfg_wdata_i,
   output logic [31:0]           cfg_rdata_o,
   // overflow detection
   input  logic                  wr_i,
   input  logic                  full_i,
   // status in, config out
   input  f2a_status_t           status_i,
   output f2a_cfg_t              cfg_o
);

   logic             en_q;
   logic             ovf_q;
   logic [LEN_W-1:0] len_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         en_q  <= 1'b0;
         ovf_q <= 1'b0;
         len_q <= LEN_W'(4);
      end else begin
         if (cfg_we_i && cfg_addr_i == ADDR_CTRL) begin
            en_q <= cfg_wdata_i[0];
         end
         if (cfg_we_i && cfg_addr_i == ADDR_LEN) begin
            len_q <= cfg_wdata_i[LEN_W-1:0];
         end
         // a new overflow wins over a clear in the same cycle
         if (wr_i && full_i) begin
            ovf_q <= 1'b1;
         end else if (cfg_we_i && cfg_addr_i == ADDR_CTRL && cfg_wdata_i[1]) begin
            ovf_q <= 1'b0;
         end
      end
   end

   always_comb begin
      cfg_rdata_o = '0;
      case (cfg_addr_i)
         ADDR_CTRL:   cfg_rdata_o[1:0] = {ovf_q, en_q};
         ADDR_LEN:    cfg_rdata_o[LEN_W-1:0] = len_q;
         ADDR_STATUS: begin
            cfg_rdata_o[1:0]  = status_i.level;
            cfg_rdata_o[15:8] = status_i.fifo_count;
         end
         default:     cfg_rdata_o = '0;
      endcase
   end

   assign cfg_o.en  = en_q;
   assign cfg_o.len = len_q;

endmodule

//--- source/f2a_credit_return.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// credit generator: initial burst of DEPTH credits, then
// one credit per fifo pop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module f2a_credit_return #(
   parameter int DEPTH = 8
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic pop_i,
   output logic credit_o
);

   localparam int OWE_W = $clog2(DEPTH + 1);

   // credits still owed to upstream, loaded with DEPTH by reset
   logic [OWE_W-1:0] owed_q;
   logic [OWE_W-1:0] owed_nxt;
   logic             issue;
   logic             credit_q;

   // one pulse per cycle, either from the owed pool or a fresh pop
   assign issue = (owed_q != '0) | pop_i;

   always_comb begin
      owed_nxt = owed_q;
      if (!pop_i && owed_q != '0) begin
         owed_nxt = owed_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         owed_q   <= OWE_W'(DEPTH);
         credit_q <= 1'b0;
      end else begin
         owed_q   <= owed_nxt;
         credit_q <= issue;
      end
   end

   assign credit_o = credit_q;

endmodule

//--- source/f2a_sync_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// synchronous fifo with registered read data and
// occupancy count
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module f2a_sync_fifo #(
   parameter int DATA_W = 32,
   parameter int DEPTH  = 8
) (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic                       wr_i,
   input  logic [DATA_W-1:0]          wdata_i,
   input  logic                       rd_i,
   output logic [DATA_W-1:0]          rdata_o,
   output logic                       empty_o,
   output logic                       full_o,
   output logic [$clog2(DEPTH+1)-1:0] count_o
);

   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [DATA_W-1:0] mem [DEPTH];
   logic [AW-1:0]     wr_ptr_q;
   logic [AW-1:0]     rd_ptr_q;
   logic [CNT_W-1:0]  count_q;
   logic [DATA_W-1:0] rdata_q;
   logic              do_wr;
   logic              do_rd;

   // writes into a full buffer are dropped
   assign do_wr = wr_i & ~full_o;
   assign do_rd = rd_i & ~empty_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_rd) begin
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         count_q <= count_q + CNT_W'(do_wr) - CNT_W'(do_rd);
      end
   end

   // storage and read data register
   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wr_ptr_q] <= wdata_i;
      end
      if (do_rd) begin
         rdata_q <= mem[rd_ptr_q];
      end
   end

   assign rdata_o = rdata_q;
   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == CNT_W'(DEPTH));
   assign count_o = count_q;

endmodule

//--- source/fifo2axis.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fifo to axi-stream converter with skid register,
// length based tlast and fill level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fifo2axis
   import f2a_pkg::*;
#(
   parameter int DATA_W = 32
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  f2a_cfg_t          cfg_i,
   // fifo side
   input  logic              fifo_empty_i,
   output logic              fifo_read_o,
   input  logic [DATA_W-1:0] fifo_rdata_i,
   // axis side
   output axis_m_t           axis_o,
   input  logic              axis_tready_i,
   output logic [1:0]        level_o
);

   logic              rd_q;
   logic              read_ok;
   logic              out_en;
   logic              saved_q;
   logic [DATA_W-1:0] skid_data_q;
   logic              skid_last_q;
   logic [LEN_W-1:0]  word_cnt_q;
   logic [LEN_W-1:0]  len_m1;
   logic              last_nxt;
   logic              out_valid_q;
   logic              out_last_q;
   logic [DATA_W-1:0] out_data_q;

   // room for another word: sink is taking data, or the
   // skid slot is empty and nothing is in flight
   assign read_ok     = axis_tready_i | ~(saved_q | rd_q);
   assign fifo_read_o = cfg_i.en & ~fifo_empty_i & read_ok;

   // output register moves when empty or accepted
   assign out_en = ~out_valid_q | axis_tready_i;

   assign len_m1   = cfg_i.len - 1'b1;
   assign last_nxt = (word_cnt_q == len_m1);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_q       <= 1'b0;
         saved_q    <= 1'b0;
         // all ones so the first pop lands on index 0
         word_cnt_q <= '1;
      end else begin
         rd_q <= fifo_read_o;
         if (out_en) begin
            saved_q <= 1'b0;
         end else if (rd_q) begin
            saved_q <= 1'b1;
         end
         if (fifo_read_o) begin
            word_cnt_q <= (word_cnt_q == len_m1) ? '0 : word_cnt_q + 1'b1;
         end
      end
   end

   // skid slot, only meaningful while saved_q is set
   always_ff @(posedge clk_i) begin
      if (rd_q) begin
         skid_data_q <= fifo_rdata_i;
         skid_last_q <= last_nxt;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_valid_q <= 1'b0;
         out_last_q  <= 1'b0;
      end else if (out_en) begin
         out_valid_q <= saved_q | rd_q;
         out_last_q  <= saved_q ? skid_last_q : last_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (out_en) begin
         out_data_q <= saved_q ? skid_data_q : fifo_rdata_i;
      end
   end

   // words held: skid plus output
   always_comb begin
      if (saved_q && out_valid_q) begin
         level_o = 2'd2;
      end else if (saved_q || out_valid_q) begin
         level_o = 2'd1;
      end else begin
         level_o = 2'd0;
      end
   end

   assign axis_o.tvalid = out_valid_q;
   assign axis_o.tlast  = out_last_q;
   assign axis_o.tdata  = out_data_q;

endmodule

//--- source/f2a_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level: credit return, fifo, converter, registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module f2a_top
   import f2a_pkg::*;
#(
   parameter int DATA_W = DATA_W_DEF,
   parameter int DEPTH  = DEPTH_DEF
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  in_word_t              in_i,
   output logic                  credit_o,
   output axis_m_t               axis_o,
   input  logic                  axis_tready_i,
   input  logic                  cfg_we_i,
   input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [31:0]           cfg_wdata_i,
   output logic [31:0]           cfg_rdata_o
);

   localparam int CNT_W = $clog2(DEPTH + 1);

   // structs carry DATA_W_DEF bits of payload
   if (DATA_W != DATA_W_DEF) begin : g_width_check
      $error("f2a_top: DATA_W must equal DATA_W_DEF");
   end

   logic              fifo_read;
   logic              fifo_empty;
   logic              fifo_full;
   logic [DATA_W-1:0] fifo_rdata;
   logic [CNT_W-1:0]  fifo_count;
   logic [1:0]        level;
   f2a_cfg_t          cfg;
   f2a_status_t       status;

   assign status.level      = level;
   assign status.fifo_count = 8'(fifo_count);

   f2a_credit_return #(
      .DEPTH(DEPTH)
   ) u_credit (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .pop_i   (fifo_read),
      .credit_o(credit_o)
   );

   f2a_sync_fifo #(
      .DATA_W(DATA_W),
      .DEPTH (DEPTH)
   ) u_fifo (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .wr_i   (in_i.valid),
      .wdata_i(in_i.data),
      .rd_i   (fifo_read),
      .rdata_o(fifo_rdata),
      .empty_o(fifo_empty),
      .full_o (fifo_full),
      .count_o(fifo_count)
   );

   fifo2axis #(
      .DATA_W(DATA_W)
   ) u_f2a (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cfg_i        (cfg),
      .fifo_empty_i (fifo_empty),
      .fifo_read_o  (fifo_read),
      .fifo_rdata_i (fifo_rdata),
      .axis_o       (axis_o),
      .axis_tready_i(axis_tready_i),
      .level_o      (level)
   );

   f2a_cfg_regs u_regs (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .cfg_we_i   (cfg_we_i),
      .cfg_addr_i (cfg_addr_i),
      .cfg_wdata_i(cfg_wdata_i),
      .cfg_rdata_o(cfg_rdata_o),
      .wr_i       (in_i.valid),
      .full_i     (fifo_full),
      .status_i   (status),
      .cfg_o      (cfg)
   );

endmodule

//--- dv/f2a_asserts.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on axis hold, credits and fifo reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module f2a_asserts
   import f2a_pkg::*;
#(
   parameter int DEPTH = 8
) (
   input logic     clk_i,
   input logic     rst_n_i,
   input in_word_t in_i,
   input logic     credit_i,
   input axis_m_t  axis_i,
   input logic     axis_tready_i,
   input logic     fifo_read_i,
   input logic     fifo_empty_i
);

   int unsigned fail_cnt = 0;
   // credits granted but not yet used by upstream
   int          held_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         held_q <= 0;
      end else begin
         held_q <= held_q + int'(credit_i) - int'(in_i.valid);
      end
   end

   a_axis_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      axis_i.tvalid && !axis_tready_i |=> $stable(axis_i))
      else begin
         fail_cnt++;
         $error("axis word changed while stalled");
      end

   a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      held_q <= DEPTH)
      else begin
         fail_cnt++;
         $error("more than DEPTH credits outstanding");
      end

   a_read_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(fifo_read_i && fifo_empty_i))
      else begin
         fail_cnt++;
         $error("fifo read while empty");
      end

   a_reset_idle: assert property (@(posedge clk_i) !rst_n_i |-> !axis_i.tvalid)
      else begin
         fail_cnt++;
         $error("tvalid high during reset");
      end

endmodule

//--- dv/f2a_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench: clock, reset, credit driven stimulus,
// register access, scoreboard, timeout and reporting
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module f2a_tb
   import f2a_pkg::*;
;
   localparam int          DEPTH = DEPTH_DEF;
   // word counts of the tests, four cycles each, plus slack
   localparam int          LIMIT = (40 + 60 + DEPTH + DEPTH + 1) * 4 + 200;
   localparam logic [31:0] SEED  = 32'h0b9dc93e;

   logic                  clk       = 1'b0;
   logic                  rst_n     = 1'b0;
   in_word_t              in_word   = '0;
   logic                  tready    = 1'b0;
   logic                  cfg_we    = 1'b0;
   logic [CFG_ADDR_W-1:0] cfg_addr  = '0;
   logic [31:0]           cfg_wdata = '0;
   logic                  credit;
   axis_m_t               axis;
   logic [31:0]           cfg_rdata;
   logic [31:0]           rd;
   logic [31:0]           data_rng  = SEED;
   logic [31:0]           ready_rng = SEED ^ 32'h5a5a_5a5a;
   int                    credits_rx, sent_cnt, sent_idx, cur_len = 4;
   int                    err_cnt, cycles, tests_run, tests_bad, err_base;
   int                    ready_mode;  // 0 low, 1 high, 2 random
   string                 test_name;
   axis_m_t               exp_q[$];
   axis_m_t               exp_w;

   f2a_top #(.DATA_W(DATA_W_DEF), .DEPTH(DEPTH)) dut (
      .clk_i(clk), .rst_n_i(rst_n), .in_i(in_word), .credit_o(credit),
      .axis_o(axis), .axis_tready_i(tready), .cfg_we_i(cfg_we),
      .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata), .cfg_rdata_o(cfg_rdata)
   );

   bind f2a_top f2a_asserts #(.DEPTH(DEPTH)) u_asserts (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .in_i(in_i), .credit_i(credit_o),
      .axis_i(axis_o), .axis_tready_i(axis_tready_i),
      .fifo_read_i(fifo_read), .fifo_empty_i(fifo_empty)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int total_errors();
      return err_cnt + int'(dut.u_asserts.fail_cnt);
   endfunction

   always @(negedge clk) begin
      ready_rng = lcg(ready_rng);
      tready <= (ready_mode == 2) ? ready_rng[28] : (ready_mode == 1);
   end

   // credit counting and the run limit
   always @(posedge clk) begin
      cycles++;
      if (rst_n && credit) credits_rx++;
      if (cycles > LIMIT) begin
         $display("timeout: run went past %0d cycles", LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   // scoreboard on accepted axis words
   always @(posedge clk) begin
      if (rst_n && axis.tvalid && tready) begin
         if (exp_q.size() == 0) begin
            $display("unexpected output word %h in %s", axis.tdata, test_name);
            err_cnt++;
         end else begin
            exp_w = exp_q.pop_front();
            check_val("tdata", exp_w.tdata, axis.tdata);
            check_val("tlast", 32'(exp_w.tlast), 32'(axis.tlast));
         end
      end
   end

   task automatic check_val(input string what, input logic [31:0] exp,
                            input logic [31:0] act);
      assert (exp === act) else begin
         $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_base  = total_errors();
      tests_run++;
   endtask

   task automatic end_test();
      int errs;
      errs = total_errors() - err_base;
      if (errs > 0) tests_bad++;
      $display("test %s: %s, %0d errors", test_name, (errs == 0) ? "ok" : "FAILED", errs);
   endtask

   task automatic apply_reset();
      rst_n   = 1'b0;
      in_word = '0;
      cfg_we  = 1'b0;
      exp_q.delete();
      credits_rx = 0;
      sent_cnt   = 0;
      sent_idx   = 0;
      cur_len    = 4;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic write_reg(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] data);
      @(negedge clk);
      cfg_we    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(negedge clk);
      cfg_we = 1'b0;
   endtask

   // read data is combinational, sampled mid cycle
   task automatic read_reg(input logic [CFG_ADDR_W-1:0] addr, output logic [31:0] data);
      @(negedge clk);
      cfg_addr = addr;
      #1;
      data = cfg_rdata;
   endtask

   // one word per cycle while a credit is held
   task automatic send_words(input int n, input bit track);
      int      i;
      axis_m_t w;
      i = 0;
      while (i < n) begin
         @(negedge clk);
         in_word.valid = 1'b0;
         if (credits_rx > sent_cnt) begin
            data_rng      = lcg(data_rng);
            in_word.valid = 1'b1;
            in_word.data  = data_rng;
            sent_cnt++;
            i++;
            if (track) begin
               w.tvalid = 1'b1;
               w.tdata  = data_rng;
               w.tlast  = (sent_idx % cur_len) == cur_len - 1;
               exp_q.push_back(w);
               sent_idx++;
            end
         end
      end
      @(negedge clk);
      in_word.valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) @(negedge clk);
   endtask

   initial begin
      start_test("initial_credits");
      apply_reset();
      repeat (DEPTH + 4) @(negedge clk);
      check_val("credits", DEPTH, credits_rx);
      end_test();

      start_test("ordering");
      ready_mode = 1;
      apply_reset();
      write_reg(ADDR_LEN, 32'd4);
      write_reg(ADDR_CTRL, 32'd1);
      send_words(40, 1'b1);
      wait_drain();
      end_test();

      start_test("backpressure");
      ready_mode = 2;
      apply_reset();
      write_reg(ADDR_LEN, 32'd5);
      cur_len = 5;
      write_reg(ADDR_CTRL, 32'd1);
      send_words(60, 1'b1);
      wait_drain();
      end_test();

      start_test("credit_status");
      ready_mode = 0;
      apply_reset();
      write_reg(ADDR_CTRL, 32'd1);
      send_words(DEPTH, 1'b1);
      // two pops fill the converter, each returns a credit
      while (credits_rx < DEPTH + 2) @(negedge clk);
      read_reg(ADDR_STATUS, rd);
      check_val("level", 32'd2, 32'(rd[1:0]));
      check_val("fifo_count", DEPTH - 2, 32'(rd[15:8]));
      check_val("credits", DEPTH + 2, credits_rx);
      ready_mode = 1;
      wait_drain();
      check_val("credits held", DEPTH, credits_rx - sent_cnt);
      end_test();

      start_test("enable_overflow");
      ready_mode = 1;
      apply_reset();
      write_reg(ADDR_CTRL, 32'd0);
      send_words(DEPTH, 1'b0);
      read_reg(ADDR_STATUS, rd);
      check_val("fifo_count", DEPTH, 32'(rd[15:8]));
      check_val("tvalid", 32'd0, 32'(axis.tvalid));
      // one write with no credit into the full fifo
      @(negedge clk);
      in_word.valid = 1'b1;
      in_word.data  = lcg(data_rng);
      @(negedge clk);
      in_word.valid = 1'b0;
      read_reg(ADDR_CTRL, rd);
      check_val("overflow set", 32'd1, 32'(rd[1]));
      write_reg(ADDR_CTRL, 32'd2);
      read_reg(ADDR_CTRL, rd);
      check_val("overflow clear", 32'd0, 32'(rd[1]));
      end_test();

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_bad, total_errors());
      if (total_errors() == 0 && tests_bad == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- verilog.f
source/f2a_pkg.sv
source/f2a_cfg_regs.sv
source/f2a_credit_return.sv
source/f2a_sync_fifo.sv
source/fifo2axis.sv
source/f2a_top.sv
dv/f2a_asserts.sv
dv/f2a_tb.sv

//--- Makefile
# Verilator build and run of the fifo to axi-stream testbench
VERILATOR  ?= verilator
TOP        ?= f2a_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS   ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
